//--- project.f
verilog/tx_pkg.sv
verilog/tx_cfg_regs.sv
verilog/tx_phase_div.sv
verilog/hr_16t4_mux.sv
verilog/qr_4t1_mux.sv
verilog/tx_top.sv
testbench/tb_clk_gen.sv
testbench/tx_checker.sv
testbench/tb_tx_top.sv

//--- testbench/tb_tx_top.sv
`timescale 1ns/1ps

`default_nettype none

module tb_tx_top import tx_pkg::*; ();

    localparam logic [31:0] SEED = 32'd9294;

    logic       clk;
    logic       arst_n;
    word_t      din;
    logic       cfg_we;
    cfg_addr_t  cfg_addr;
    word_t      cfg_wdata;
    word_t      cfg_rdata;
    logic       prbs_strobe;
    logic       dout_p;
    logic       dout_n;
    logic [2:0] test_id;
    int         chk_errors;    // From the checker
    int         bits_checked;
    int         tb_errors;     // Read-back and run-level failures
    logic [31:0] lcg_state = SEED;

    tb_clk_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    tx_top uut (
        .mdll_clk    (clk),
        .arst_n      (arst_n),
        .din         (din),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .prbs_strobe (prbs_strobe),
        .dout_p      (dout_p),
        .dout_n      (dout_n)
    );

    tx_checker u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .din          (din),
        .prbs_strobe  (prbs_strobe),
        .dout_p       (dout_p),
        .dout_n       (dout_n),
        .test_id      (test_id),
        .err_count    (chk_errors),
        .bits_checked (bits_checked)
    );

    // Numerical Recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Word source, next word right after the DUT samples the current one
    always @(posedge clk) begin
        if (prbs_strobe === 1'b1) begin
            lcg_state = lcg_next(lcg_state);
            din <= lcg_state[31:16];  // Upper bits, better spread
        end
    end

    task automatic fail_timeout(input string what);
        $display("Timeout: %s did not happen in time", what);
        $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1)
            fail_timeout("reset release");
    endtask

    // One cycle with cfg_we high
    task automatic write_reg(input cfg_addr_t addr, input word_t data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic check_read(input string name, input cfg_addr_t addr, input word_t exp);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        if (cfg_rdata !== exp) begin
            $display("ERROR %s: read-back expected %h, actual %h", name, exp, cfg_rdata);
            tb_errors++;
        end
    endtask

    // Counts words taken by the DUT
    task automatic wait_words(input int n);
        int seen;
        int cycles;
        int limit;
        seen   = 0;
        cycles = 0;
        limit  = 16 * n + 40;
        while (seen < n && cycles < limit) begin
            @(posedge clk);
            cycles++;
            if (prbs_strobe === 1'b1)
                seen++;
        end
        if (seen < n)
            fail_timeout("a word request on prbs_strobe");
    endtask

    // Set mode while off, enable, stream, disable
    task automatic run_stream(input logic [2:0] id, input word_t ctrl, input int words);
        test_id = id;
        write_reg(ADDR_CTRL, ctrl);
        write_reg(ADDR_CTRL, ctrl | 16'h0001);
        wait_words(words);
        repeat (18) @(posedge clk);  // Last word needs t+2..t+17
        write_reg(ADDR_CTRL, 16'h0000);
        repeat (4) @(posedge clk);
    endtask

    initial begin
        lcg_state = lcg_next(lcg_state);
        din       = lcg_state[31:16];
        cfg_we    = 1'b0;
        cfg_addr  = ADDR_CTRL;
        cfg_wdata = '0;
        test_id   = 3'd0;
        tb_errors = 0;

        wait_reset_release();
        repeat (4) @(posedge clk);

        // Register map, en kept low
        check_read("reset_values", ADDR_CTRL, 16'h0000);
        check_read("reset_values", ADDR_PATTERN, 16'h0000);
        write_reg(ADDR_CTRL, 16'hFFF6);
        check_read("ctrl_readback", ADDR_CTRL, 16'h0006);  // Upper bits not stored
        write_reg(ADDR_PATTERN, 16'hC35A);
        check_read("pattern_readback", ADDR_PATTERN, 16'hC35A);
        write_reg(2'd2, 16'hFFFF);
        check_read("unmapped_readback", 2'd2, 16'h0000);
        check_read("unmapped_readback", 2'd3, 16'h0000);
        check_read("pattern_readback", ADDR_PATTERN, 16'hC35A);
        write_reg(ADDR_CTRL, 16'h0000);
        check_read("ctrl_readback", ADDR_CTRL, 16'h0000);

        run_stream(3'd1, 16'h0000, 40);  // MSB first
        run_stream(3'd2, 16'h0004, 20);  // LSB first
        run_stream(3'd3, 16'h0008, 10);  // Pattern, din ignored
        run_stream(3'd4, 16'h0002, 20);  // Swapped pins
        test_id = 3'd0;
        repeat (8) @(posedge clk);

        // 90 words in all
        if (bits_checked < 16 * 90) begin
            $display("Checker compared only %0d serial bits, the stream fell short",
                     bits_checked);
            tb_errors++;
        end

        $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tx_checker.sv
`timescale 1ns/1ps

`default_nettype none

module tx_checker import tx_pkg::*; (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       cfg_we,       // Register writes, mirrored
    input  wire cfg_addr_t  cfg_addr,
    input  wire word_t      cfg_wdata,
    input  wire word_t      din,
    input  wire logic       prbs_strobe,
    input  wire logic       dout_p,
    input  wire logic       dout_n,
    input  wire logic [2:0] test_id,      // Selects the name in error lines
    output int              err_count,
    output int              bits_checked
);

    tx_cfg_t shadow;        // Mirror of the DUT controls
    int      cyc;           // Negedge count since reset release
    int      en_cycles;     // Cycles since en rose
    bit      exp_bit_q[$];  // Expected serial bits
    int      exp_due_q[$];  // Cycle each bit is due on the line

    // Expected line bit for send slot 0..15
    function automatic logic expected_bit(input word_t w, input logic lsb_first,
                                          input logic pat_en, input word_t pattern,
                                          input int slot);
        word_t src;
        src = pat_en ? pattern : w;
        expected_bit = lsb_first ? src[slot] : src[15 - slot];
    endfunction

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd0:    test_label = "reset_idle";
            3'd1:    test_label = "msb_first";
            3'd2:    test_label = "lsb_first";
            3'd3:    test_label = "pattern";
            3'd4:    test_label = "swap_pol";
            default: test_label = "unknown";
        endcase
    endfunction

    initial begin
        err_count    = 0;
        bits_checked = 0;
        cyc          = 0;
        en_cycles    = 0;
    end

    // Same edge as the DUT register block
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shadow <= '0;
        end else if (cfg_we) begin
            if (cfg_addr == ADDR_CTRL) begin
                shadow.en        <= cfg_wdata[CTRL_EN];
                shadow.swap_pol  <= cfg_wdata[CTRL_SWAP];
                shadow.lsb_first <= cfg_wdata[CTRL_LSB];
                shadow.pat_en    <= cfg_wdata[CTRL_PAT];
            end else if (cfg_addr == ADDR_PATTERN) begin
                shadow.pattern <= cfg_wdata;
            end
        end
    end

    // Sample mid-cycle, outputs settled
    always @(negedge clk) begin : monitor
        logic exp_b;
        logic exp_p;
        logic exp_s;
        if (arst_n) begin
            cyc = cyc + 1;
            if (!shadow.en) begin
                if (prbs_strobe !== 1'b0 || dout_p !== 1'b0 || dout_n !== 1'b0) begin
                    $display("ERROR %s: strobe/p/n expected 000, actual %b%b%b",
                             test_label(test_id), prbs_strobe, dout_p, dout_n);
                    err_count++;
                end
                exp_bit_q.delete();  // Words in flight are dropped
                exp_due_q.delete();
                en_cycles = 0;
            end else begin
                en_cycles++;
                exp_s = (en_cycles % 16 == 0);  // 16th enabled cycle, then every 16
                if (prbs_strobe !== exp_s) begin
                    $display("ERROR %s: prbs_strobe in enabled cycle %0d expected %b, actual %b",
                             test_label(test_id), en_cycles, exp_s, prbs_strobe);
                    err_count++;
                end
                if (dout_n !== ~dout_p) begin
                    $display("ERROR %s: dout_n expected %b, actual %b",
                             test_label(test_id), ~dout_p, dout_n);
                    err_count++;
                end
                if (exp_due_q.size() > 0 && exp_due_q[0] == cyc) begin
                    exp_b = exp_bit_q.pop_front();
                    void'(exp_due_q.pop_front());
                    exp_p = exp_b ^ shadow.swap_pol;  // Swap puts the bit on dout_n
                    if (dout_p !== exp_p) begin
                        $display("ERROR %s: dout_p expected %b, actual %b",
                                 test_label(test_id), exp_p, dout_p);
                        err_count++;
                    end
                    bits_checked++;
                end
                // Word sampled now leaves from cyc+2
                if (prbs_strobe === 1'b1) begin
                    for (int i = 0; i < 16; i++) begin
                        exp_bit_q.push_back(expected_bit(din, shadow.lsb_first,
                                                         shadow.pat_en, shadow.pattern, i));
                        exp_due_q.push_back(cyc + 2 + i);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps

`default_nettype none

module tb_clk_gen (
    output logic clk,     // Stands in for mdll_clk
    output logic arst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset low for the first 2 rising edges
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/tx_top.sv
`timescale 1ns/1ps

`default_nettype none

module tx_top import tx_pkg::*; (
    input  wire logic      mdll_clk,     // Bit-rate clock from MDLL
    input  wire logic      arst_n,
    input  wire word_t     din,          // Word from the external source
    input  wire logic      cfg_we,
    input  wire cfg_addr_t cfg_addr,
    input  wire word_t     cfg_wdata,
    output word_t          cfg_rdata,
    output logic           prbs_strobe,  // Next word request
    output logic           dout_p,
    output logic           dout_n
);

    tx_cfg_t cfg;          // Controls to the datapath
    logic    quad_strobe;  // Nibble pacing
    quad_t   quad;         // 16:4 to 4:1 nibble

    // Register block beside the datapath
    tx_cfg_regs u_cfg_regs (
        .mdll_clk  (mdll_clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg)
    );

    // Strobes in place of divided clocks
    tx_phase_div u_phase_div (
        .mdll_clk    (mdll_clk),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .quad_strobe (quad_strobe),
        .prbs_strobe (prbs_strobe)
    );

    // Half-rate stage, word to nibbles
    hr_16t4_mux u_hr_mux (
        .mdll_clk    (mdll_clk),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .din         (din),
        .quad_strobe (quad_strobe),
        .prbs_strobe (prbs_strobe),
        .quad        (quad)
    );

    // Quarter-rate stage, nibble to line
    qr_4t1_mux u_qr_mux (
        .mdll_clk (mdll_clk),
        .arst_n   (arst_n),
        .cfg      (cfg),
        .quad     (quad),
        .dout_p   (dout_p),
        .dout_n   (dout_n)
    );

endmodule

`default_nettype wire

//--- verilog/qr_4t1_mux.sv
`timescale 1ns/1ps

`default_nettype none

module qr_4t1_mux import tx_pkg::*; (
    input  wire logic    mdll_clk,  // Bit-rate clock
    input  wire logic    arst_n,
    input  wire tx_cfg_t cfg,
    input  wire quad_t   quad,      // Nibble from the 16:4 stage
    output logic         dout_p,
    output logic         dout_n
);

    logic [1:0] qphase;  // 0 Q, 1 I, 2 QB, 3 IB
    logic       bit_q;   // Output register
    logic       line_bit;

    // Runs in step with the low bits of the word phase
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            qphase <= '0;
        end else if (!cfg.en) begin
            qphase <= '0;
        end else begin
            qphase <= qphase + 2'd1;
        end
    end

    // One bit per cycle, Q first
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_q <= 1'b0;
        end else if (!cfg.en) begin
            bit_q <= 1'b0;
        end else begin
            bit_q <= quad[qphase];
        end
    end

    assign line_bit = bit_q ^ cfg.swap_pol;  // Swap exchanges the pins

    // Differential pair, both low when off
    assign dout_p = cfg.en & line_bit;
    assign dout_n = cfg.en & ~line_bit;

    // Pins must stay complementary through a running stream
    a_diff_pair: assert property (
        @(posedge mdll_clk) disable iff (!arst_n)
        cfg.en ##1 cfg.en |-> (dout_p ^ dout_n)
    ) else $error("dout_p equals dout_n while enabled");

endmodule

`default_nettype wire

//--- verilog/hr_16t4_mux.sv
`timescale 1ns/1ps

`default_nettype none

module hr_16t4_mux import tx_pkg::*; (
    input  wire logic    mdll_clk,     // Bit-rate clock
    input  wire logic    arst_n,
    input  wire tx_cfg_t cfg,
    input  wire word_t   din,          // Valid while prbs_strobe is high
    input  wire logic    quad_strobe,
    input  wire logic    prbs_strobe,
    output quad_t        quad          // Nibble to the 4:1 stage
);

    word_t src_word;  // din or pattern
    word_t reo_word;  // Interleaved word
    word_t word_q;    // Remaining nibbles, shifted down

    // Bits of nibble 0 sit at 0, 4, 8, 12
    function automatic quad_t pick_quad(input word_t w);
        pick_quad = {w[12], w[8], w[4], w[0]};
    endfunction

    assign src_word = cfg.pat_en ? cfg.pattern : din;

    // Position 4k+j carries send slot 4j+k
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 4; j++) begin
                if (cfg.lsb_first)
                    reo_word[4*k+j] = src_word[4*j+k];       // Slot 0 is din[0]
                else
                    reo_word[4*k+j] = src_word[15-(4*j+k)];  // Slot 0 is din[15]
            end
        end
    end

    // Nibble 0 goes straight out, rest waits in word_q
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            word_q <= '0;
            quad   <= '0;
        end else if (prbs_strobe) begin
            word_q <= reo_word >> 1;
            quad   <= pick_quad(reo_word);
        end else if (quad_strobe) begin
            word_q <= word_q >> 1;  // Next nibble moves to 0, 4, 8, 12
            quad   <= pick_quad(word_q);
        end
    end

    // Strobes must stay quiet while the transmitter is off
    a_no_strobe_disabled: assert property (
        @(posedge mdll_clk) disable iff (!arst_n)
        !cfg.en |-> !quad_strobe
    ) else $error("quad_strobe while transmitter disabled");

endmodule

`default_nettype wire

//--- verilog/tx_phase_div.sv
`timescale 1ns/1ps

`default_nettype none

module tx_phase_div import tx_pkg::*; (
    input  wire logic    mdll_clk,     // Bit-rate clock
    input  wire logic    arst_n,
    input  wire tx_cfg_t cfg,
    output logic         quad_strobe,  // Last bit of a nibble
    output logic         prbs_strobe   // Last bit of a word, asks for next din
);

    phase_t phase;  // Bit position in the current word

    // Replaces the div-by-2 chain, free runs 0..15 while enabled
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
        end else if (!cfg.en) begin
            phase <= '0;  // Parked until enabled
        end else begin
            phase <= phase + phase_t'(1);  // Wraps 15 -> 0
        end
    end

    // Phases 3, 7, 11, 15
    assign quad_strobe = cfg.en & (phase[1:0] == 2'b11);

    // Phase 15 only, stands in for clk_prbsgen
    assign prbs_strobe = cfg.en & (phase == phase_t'(15));

    // Word boundary is always a nibble boundary too
    a_prbs_on_quad: assert property (
        @(posedge mdll_clk) disable iff (!arst_n)
        prbs_strobe |-> quad_strobe
    ) else $error("prbs_strobe without quad_strobe");

endmodule

`default_nettype wire

//--- verilog/tx_cfg_regs.sv
`timescale 1ns/1ps

`default_nettype none

module tx_cfg_regs import tx_pkg::*; (
    input  wire logic      mdll_clk,   // Bit-rate clock
    input  wire logic      arst_n,
    input  wire logic      cfg_we,     // Write strobe
    input  wire cfg_addr_t cfg_addr,
    input  wire word_t     cfg_wdata,
    output word_t          cfg_rdata,  // Combinational read-back
    output tx_cfg_t        cfg
);

    logic [3:0] ctrl_q;     // en, swap, lsb, pat
    word_t      pattern_q;

    // Write decode, one cycle to cfg
    always_ff @(posedge mdll_clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q    <= '0;
            pattern_q <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                ADDR_CTRL:    ctrl_q    <= cfg_wdata[3:0];
                ADDR_PATTERN: pattern_q <= cfg_wdata;
                default:      ;  // Unmapped address, write dropped
            endcase
        end
    end

    // Fan control bits out into the struct
    always_comb begin
        cfg.en        = ctrl_q[CTRL_EN];
        cfg.swap_pol  = ctrl_q[CTRL_SWAP];
        cfg.lsb_first = ctrl_q[CTRL_LSB];
        cfg.pat_en    = ctrl_q[CTRL_PAT];
        cfg.pattern   = pattern_q;
    end

    // Read mux, unused bits zero
    always_comb begin
        case (cfg_addr)
            ADDR_CTRL:    cfg_rdata = {12'd0, ctrl_q};
            ADDR_PATTERN: cfg_rdata = pattern_q;
            default:      cfg_rdata = '0;
        endcase
    end

    // A write must hit a defined register
    a_we_addr_known: assert property (
        @(posedge mdll_clk) disable iff (!arst_n)
        cfg_we |-> !$isunknown(cfg_addr)
    ) else $error("cfg_addr unknown during a register write");

endmodule

`default_nettype wire

//--- verilog/tx_pkg.sv
`default_nettype none

package tx_pkg;

    // Widths with a meaning of their own
    typedef logic [15:0] word_t;      // Parallel word from the word source
    typedef logic [3:0]  quad_t;      // One quarter-rate nibble
    typedef logic [3:0]  phase_t;     // Bit position inside a word
    typedef logic [1:0]  cfg_addr_t;  // Register address

    // Register map
    localparam cfg_addr_t ADDR_CTRL    = 2'd0;  // Control bits in [3:0]
    localparam cfg_addr_t ADDR_PATTERN = 2'd1;  // Fixed pattern word

    // Control bit positions inside ADDR_CTRL
    localparam int unsigned CTRL_EN   = 0;
    localparam int unsigned CTRL_SWAP = 1;
    localparam int unsigned CTRL_LSB  = 2;
    localparam int unsigned CTRL_PAT  = 3;

    // Transmitter controls as seen by the datapath, 20 bits
    typedef struct packed {
        logic  en;         // Transmitter enable
        logic  swap_pol;   // Exchange dout_p and dout_n
        logic  lsb_first;  // din[0] goes out first
        logic  pat_en;     // Send pattern instead of din
        word_t pattern;    // Fixed pattern word
    } tx_cfg_t;

endpackage

`default_nettype wire
